/* project.f */
+incdir+source
source/rp_pkg.sv
source/adc_frontend.sv
source/dac_mixer.sv
source/dac_formatter.sv
source/sys_bus_decoder.sv
source/rp_top.sv
test/rp_top_properties.sv
test/tb_rp_top.sv

/* source/adc_frontend.sv */
// first pipeline stage, turns the raw adc codes into two's complement and registers them
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  logic                 adc_clk,    // sample clock
  input  logic                 reset_i,    // sync, active high
  input  rp_pkg::raw_pair_t    adc_raw_i,  // straight from the converter
  output rp_pkg::sample_pair_t adc_o       // to the applications
);

  import rp_pkg::*;

  sample_pair_t adc_conv;  // unregistered conversion

  //------------------------------
  // format conversion
  always_comb begin
    adc_conv.a = sample_t'(flip_code(adc_raw_i.a));  // ch1
    adc_conv.b = sample_t'(flip_code(adc_raw_i.b));  // ch2
  end

  //------------------------------
  // output register
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_o <= '0;        // both channels read as zero
    end else begin
      adc_o <= adc_conv;  // one cycle latency
    end
  end

endmodule

`default_nettype wire

/* source/dac_formatter.sv */
// third pipeline stage, maps the mixed two's complement samples to dac code and registers them
`timescale 1ns/1ps
`default_nettype none

module dac_formatter (
  input  logic                 adc_clk,  // sample clock
  input  logic                 reset_i,  // sync, active high
  input  rp_pkg::sample_pair_t mix_i,    // from the mixer
  output rp_pkg::raw_pair_t    dac_o     // to the converter, both channels in parallel
);

  import rp_pkg::*;

  localparam raw_t ZERO_CODE = raw_t'(flip_code('0));  // 0x1FFF, mid scale

  raw_pair_t dac_conv;

  //------------------------------
  // format conversion
  always_comb begin
    dac_conv.a = raw_t'(flip_code(mix_i.a));
    dac_conv.b = raw_t'(flip_code(mix_i.b));
  end

  //------------------------------
  // output register
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_o.a <= ZERO_CODE;  // converter idles at zero volts
      dac_o.b <= ZERO_CODE;
    end else begin
      dac_o <= dac_conv;
    end
  end

endmodule

`default_nettype wire

/* source/dac_mixer.sv */
// second pipeline stage, adds generator and controller samples per channel with saturation
`timescale 1ns/1ps
`default_nettype none

`include "rp_params.svh"

module dac_mixer (
  input  logic                 adc_clk,  // sample clock
  input  logic                 reset_i,  // sync, active high
  input  rp_pkg::sample_pair_t asg_i,    // generator samples
  input  rp_pkg::sample_pair_t pid_i,    // controller samples
  output rp_pkg::sample_pair_t mix_o     // clamped sum
);

  import rp_pkg::*;

  logic signed [`RP_SUM_W-1:0] sum_a;  // ch1 with guard bit
  logic signed [`RP_SUM_W-1:0] sum_b;  // ch2 with guard bit
  sample_pair_t                mix_sat;

  // top two bits disagree only when the 14-bit range is left
  function automatic sample_t saturate(input logic signed [`RP_SUM_W-1:0] s);
    sample_t res;
    case (s[`RP_SUM_W-1 -: 2])
      2'b01:   res = `RP_SAT_POS;             // pos. overflow
      2'b10:   res = `RP_SAT_NEG;             // neg. overflow
      default: res = s[`RP_SAMPLE_W-1:0];     // fits, drop guard bit
    endcase
    return res;
  endfunction

  //------------------------------
  // sum and clamp
  assign sum_a = asg_i.a + pid_i.a;  // sign extended into 15 bits
  assign sum_b = asg_i.b + pid_i.b;

  always_comb begin
    mix_sat.a = saturate(sum_a);
    mix_sat.b = saturate(sum_b);
  end

  //------------------------------
  // output register
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      mix_o <= '0;
    end else begin
      mix_o <= mix_sat;  // one cycle latency
    end
  end

endmodule

`default_nettype wire

/* source/rp_params.svh */
// widths, region map and clamp limits for the sample path and system bus, pulled in by `include
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

//------------------------------
// sample path
`define RP_SAMPLE_W   14          // adc and dac word
`define RP_SUM_W      15          // mixer sum, one guard bit
`define RP_SAT_POS    14'h1FFF    // clamp on positive overflow
`define RP_SAT_NEG    14'h2000    // clamp on negative overflow

//------------------------------
// system bus
`define RP_BUS_W      32          // data and address
`define RP_SEL_W      4           // byte selects
`define RP_REGIONS    8           // slave regions
`define RP_REGION_LSB 20          // region field low bit
`define RP_REGION_MSB 22          // region field high bit

`endif

/* source/rp_pkg.sv */
// shared sample, pair and bus types plus the code conversion, imported by every rtl module
`default_nettype none

`include "rp_params.svh"

package rp_pkg;

  //------------------------------
  // sample path
  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t;  // two's complement
  typedef logic        [`RP_SAMPLE_W-1:0] raw_t;     // offset binary, negative slope

  typedef struct packed {
    raw_t a;  // channel 1
    raw_t b;  // channel 2
  } raw_pair_t;

  typedef struct packed {
    sample_t a;  // channel 1
    sample_t b;  // channel 2
  } sample_pair_t;

  // same bit mapping in both directions, so adc and dac share it
  function automatic logic [`RP_SAMPLE_W-1:0] flip_code(input logic [`RP_SAMPLE_W-1:0] w);
    return {w[`RP_SAMPLE_W-1], ~w[`RP_SAMPLE_W-2:0]};  // top bit kept, rest inverted
  endfunction

  //------------------------------
  // system bus
  typedef struct packed {
    logic [`RP_BUS_W-1:0] addr;   // bits 22..20 pick the region
    logic [`RP_BUS_W-1:0] wdata;
    logic [`RP_SEL_W-1:0] sel;    // byte select
    logic                 wen;    // write strobe
    logic                 ren;    // read strobe
  } bus_req_t;

  typedef struct packed {
    logic [`RP_BUS_W-1:0] rdata;
    logic                 err;
    logic                 ack;    // raised by the slave when done
  } bus_rsp_t;

  typedef bus_rsp_t [`RP_REGIONS-1:0] region_rsp_t;  // one response per region
  typedef logic     [`RP_REGIONS-1:0] region_en_t;   // one strobe per region

endpackage

`default_nettype wire

/* source/rp_top.sv */
// board top level, joins the adc to dac sample pipeline and the system bus decoder
`timescale 1ns/1ps
`default_nettype none

module rp_top (
  input  logic                 adc_clk,       // sample clock, also used by the bus side
  input  logic                 reset_i,       // sync, active high

  // sample path
  input  rp_pkg::raw_pair_t    adc_raw_i,     // adc pins
  input  rp_pkg::sample_pair_t asg_i,         // generator output
  input  rp_pkg::sample_pair_t pid_i,         // controller output
  output rp_pkg::sample_pair_t adc_o,         // converted adc to the applications
  output rp_pkg::raw_pair_t    dac_o,         // dac pins

  // system bus
  input  rp_pkg::bus_req_t     bus_req_i,     // master request
  input  rp_pkg::region_rsp_t  region_rsp_i,  // slave replies
  output rp_pkg::region_en_t   region_wen_o,
  output rp_pkg::region_en_t   region_ren_o,
  output rp_pkg::bus_rsp_t     bus_rsp_o      // selected reply
);

  import rp_pkg::*;

  sample_pair_t mix;  // mixer to formatter

  //------------------------------
  // adc side
  adc_frontend i_adc (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .adc_raw_i (adc_raw_i),
    .adc_o     (adc_o)       // 1 cycle
  );

  //------------------------------
  // dac side
  dac_mixer i_mix (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .asg_i   (asg_i),
    .pid_i   (pid_i),
    .mix_o   (mix)           // 1 cycle
  );

  dac_formatter i_dac (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .mix_i   (mix),
    .dac_o   (dac_o)         // 2 cycles from asg/pid
  );

  //------------------------------
  // bus decoder
  sys_bus_decoder i_dec (
    .bus_req_i    (bus_req_i),
    .region_rsp_i (region_rsp_i),
    .region_wen_o (region_wen_o),
    .region_ren_o (region_ren_o),
    .bus_rsp_o    (bus_rsp_o)    // same cycle
  );

endmodule

`default_nettype wire

/* source/sys_bus_decoder.sv */
// combinational system bus decoder, splits the address space into regions and muxes the replies
`timescale 1ns/1ps
`default_nettype none

`include "rp_params.svh"

module sys_bus_decoder (
  input  rp_pkg::bus_req_t    bus_req_i,     // from the bus master
  input  rp_pkg::region_rsp_t region_rsp_i,  // replies of all slaves
  output rp_pkg::region_en_t  region_wen_o,  // per region write strobe
  output rp_pkg::region_en_t  region_ren_o,  // per region read strobe
  output rp_pkg::bus_rsp_t    bus_rsp_o      // back to the master
);

  import rp_pkg::*;

  localparam int IDX_W = `RP_REGION_MSB - `RP_REGION_LSB + 1;  // 3 bits for 8 regions

  logic [IDX_W-1:0] region_idx;  // address field
  region_en_t       region_cs;   // one-hot chip select

  //------------------------------
  // chip select
  assign region_idx = bus_req_i.addr[`RP_REGION_MSB:`RP_REGION_LSB];
  assign region_cs  = region_en_t'(1) << region_idx;

  // strobes follow the master level, no state
  assign region_wen_o = region_cs & {`RP_REGIONS{bus_req_i.wen}};
  assign region_ren_o = region_cs & {`RP_REGIONS{bus_req_i.ren}};

  //------------------------------
  // response mux
  always_comb begin
    bus_rsp_o = '0;
    for (int r = 0; r < `RP_REGIONS; r++) begin
      if (region_cs[r]) begin
        bus_rsp_o = region_rsp_i[r];  // rdata, err and ack of the selected slave
      end
    end
  end

endmodule

`default_nettype wire

/* test/rp_top_properties.sv */
// concurrent checks of the sample pipeline and bus decoder, bound into rp_top by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "rp_params.svh"

module rp_top_properties (
  input logic                 adc_clk,
  input logic                 reset_i,
  input rp_pkg::raw_pair_t    adc_raw_i,
  input rp_pkg::sample_pair_t asg_i,
  input rp_pkg::sample_pair_t pid_i,
  input rp_pkg::sample_pair_t adc_o,
  input rp_pkg::raw_pair_t    dac_o,
  input rp_pkg::bus_req_t     bus_req_i,
  input rp_pkg::region_rsp_t  region_rsp_i,
  input rp_pkg::region_en_t   region_wen_o,
  input rp_pkg::region_en_t   region_ren_o,
  input rp_pkg::bus_rsp_t     bus_rsp_o
);

  import rp_pkg::*;

  localparam int MAX_S = 2 ** (`RP_SAMPLE_W - 1) - 1;  // 8191
  localparam int MIN_S = -(2 ** (`RP_SAMPLE_W - 1));   // -8192

  int unsigned  pass_count = 0;  // read by the testbench
  int unsigned  fail_count = 0;
  int unsigned  edges = 0;       // history is valid after two edges
  logic         rst_q;           // reset seen at the last edge
  logic         rst_qq;          // and the one before
  raw_pair_t    raw_q;
  sample_pair_t asg_q;
  sample_pair_t pid_q;
  sample_pair_t asg_qq;
  sample_pair_t pid_qq;
  sample_pair_t exp_adc;
  raw_pair_t    exp_dac;
  region_en_t   exp_cs;
  region_en_t   exp_wen;
  region_en_t   exp_ren;
  bus_rsp_t     exp_rsp;
  int           sel_idx;         // region number from the address

  // clamp the true sum into 14 bits, the dac code of value v is 8191 - v
  function automatic raw_t dac_expect(input sample_t g, input sample_t p);
    int s;
    s = int'(g) + int'(p);                                   // no wrap in 32 bits
    s = (s > MAX_S) ? MAX_S : ((s < MIN_S) ? MIN_S : s);
    return raw_t'(MAX_S - s);
  endfunction

  //------------------------------
  // input history
  always @(posedge adc_clk) begin
    edges  <= edges + 1;
    rst_q  <= reset_i;
    rst_qq <= rst_q;
    raw_q  <= adc_raw_i;
    asg_q  <= asg_i;
    pid_q  <= pid_i;
    asg_qq <= asg_q;  // two edges back for the dac side
    pid_qq <= pid_q;
  end

  //------------------------------
  // expected values
  always_comb begin
    exp_adc.a = rst_q ? '0 : sample_t'(MAX_S - int'(raw_q.a));  // raw c reads as 8191 - c
    exp_adc.b = rst_q ? '0 : sample_t'(MAX_S - int'(raw_q.b));
    // a reset on either of the last two edges leaves the zero code
    exp_dac.a = (rst_q || rst_qq) ? raw_t'(MAX_S) : dac_expect(asg_qq.a, pid_qq.a);
    exp_dac.b = (rst_q || rst_qq) ? raw_t'(MAX_S) : dac_expect(asg_qq.b, pid_qq.b);
    sel_idx   = int'(bus_req_i.addr[`RP_REGION_MSB:`RP_REGION_LSB]);
    for (int r = 0; r < `RP_REGIONS; r++) begin
      exp_cs[r] = (sel_idx == r);  // one hot
    end
    exp_wen = bus_req_i.wen ? exp_cs : '0;
    exp_ren = bus_req_i.ren ? exp_cs : '0;
    exp_rsp = region_rsp_i[sel_idx];
  end

  //------------------------------
  // checks, mid cycle when all inputs have settled
  adc_check: assert property (@(negedge adc_clk) disable iff (edges < 2) adc_o == exp_adc)
    pass_count++;
  else begin
    fail_count++;
    $error("FAIL t=%0t adc_o exp=%h got=%h", $time, exp_adc, adc_o);
  end

  dac_check: assert property (@(negedge adc_clk) disable iff (edges < 2) dac_o == exp_dac)
    pass_count++;
  else begin
    fail_count++;
    $error("FAIL t=%0t dac_o exp=%h got=%h", $time, exp_dac, dac_o);
  end

  wen_check: assert property (@(negedge adc_clk) disable iff (edges < 2) region_wen_o == exp_wen)
    pass_count++;
  else begin
    fail_count++;
    $error("FAIL t=%0t region_wen_o exp=%b got=%b", $time, exp_wen, region_wen_o);
  end

  ren_check: assert property (@(negedge adc_clk) disable iff (edges < 2) region_ren_o == exp_ren)
    pass_count++;
  else begin
    fail_count++;
    $error("FAIL t=%0t region_ren_o exp=%b got=%b", $time, exp_ren, region_ren_o);
  end

  rsp_check: assert property (@(negedge adc_clk) disable iff (edges < 2) bus_rsp_o == exp_rsp)
    pass_count++;
  else begin
    fail_count++;
    $error("FAIL t=%0t bus_rsp_o exp=%h got=%h", $time, exp_rsp, bus_rsp_o);
  end

endmodule

`default_nettype wire

/* test/tb_rp_top.sv */
// testbench for rp_top, drives directed and random samples plus bus traffic for the bound checks
`timescale 1ns/1ps
`default_nettype none

`include "rp_params.svh"

module tb_rp_top;

  import rp_pkg::*;

  localparam int CLK_PERIOD     = 8;    // ns
  localparam int DRIVE_DELAY    = 1;    // ns after the rising edge
  localparam int RESET_CYCLES   = 4;
  localparam int STIM_CYCLES    = 400;
  localparam int DRAIN_CYCLES   = 4;    // empties the two stage dac path
  localparam int TIMEOUT_CYCLES = (RESET_CYCLES + STIM_CYCLES + DRAIN_CYCLES) * 3 / 2;
  localparam sample_t S_MAX     = 14'sh1FFF;  // largest sample
  localparam sample_t S_MIN     = 14'sh2000;  // smallest sample

  logic         adc_clk;
  logic         reset_i;
  raw_pair_t    adc_raw_i;
  sample_pair_t asg_i;
  sample_pair_t pid_i;
  sample_pair_t adc_o;
  raw_pair_t    dac_o;
  bus_req_t     bus_req_i;
  region_rsp_t  region_rsp_i;
  region_en_t   region_wen_o;
  region_en_t   region_ren_o;
  bus_rsp_t     bus_rsp_o;
  int unsigned  cycle_count;
  int unsigned  checks;
  int unsigned  errors;

  rp_top uut (.*);

  bind rp_top rp_top_properties props (.*);  // all checking lives here

  //------------------------------
  // clock and timeout
  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge adc_clk);
      cycle_count++;
    end
    $display("timeout at cycle %0d, stimulus never finished, checks=%0d errors=%0d",
             cycle_count, uut.props.pass_count, uut.props.fail_count);
    $display("STATUS: FAIL");
    $finish;
  end

  //------------------------------
  // stimulus
  task automatic set_sums(input sample_t ga, input sample_t pa,
                          input sample_t gb, input sample_t pb);
    asg_i.a = ga;
    pid_i.a = pa;
    asg_i.b = gb;
    pid_i.b = pb;
  endtask

  // raw extremes every 16 cycles, sum corners every 8, random otherwise
  task automatic drive_samples(input int k);
    adc_raw_i.a = raw_t'($urandom);
    adc_raw_i.b = raw_t'($urandom);
    asg_i.a     = sample_t'($urandom);
    asg_i.b     = sample_t'($urandom);
    pid_i.a     = sample_t'($urandom);
    pid_i.b     = sample_t'($urandom);
    case (k % 16)
      0: begin
        adc_raw_i.a = 14'h0000;  // full scale positive
        adc_raw_i.b = 14'h3FFF;  // full scale negative
      end
      1: adc_raw_i.b = 14'h2000;  // just below zero
      default: ;
    endcase
    case (k % 8)
      0: set_sums(S_MAX, S_MAX, S_MIN, S_MIN);                         // deep overflow
      1: set_sums(S_MAX, 14'sd1, S_MIN, -14'sd1);                      // one step past
      2: set_sums(14'sd4000, 14'sd4191, -14'sd4096, -14'sd4096);       // right on the limits
      default: ;
    endcase
  endtask

  task automatic drive_bus();
    logic [31:0] rnd;
    rnd             = $urandom;
    bus_req_i.addr  = $urandom;
    bus_req_i.wdata = $urandom;
    bus_req_i.sel   = rnd[`RP_SEL_W-1:0];
    bus_req_i.wen   = rnd[4];  // both low a quarter of the time
    bus_req_i.ren   = rnd[5];
    for (int r = 0; r < `RP_REGIONS; r++) begin
      region_rsp_i[r].rdata = $urandom;
      region_rsp_i[r].err   = rnd[8 + 2 * r];
      region_rsp_i[r].ack   = rnd[9 + 2 * r];
    end
  endtask

  //------------------------------
  // main sequence
  initial begin
    void'($urandom(46));  // seed once
    reset_i      = 1'b1;
    adc_raw_i    = '0;
    asg_i        = '0;
    pid_i        = '0;
    bus_req_i    = '0;
    region_rsp_i = '0;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    for (int k = 0; k < STIM_CYCLES; k++) begin
      drive_samples(k);
      drive_bus();
      @(posedge adc_clk);
      #DRIVE_DELAY;
    end
    repeat (DRAIN_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    checks = uut.props.pass_count;
    errors = uut.props.fail_count;
    if (checks == 0) begin
      $display("no assertion was ever evaluated, the bound checker did not run");
      errors++;
    end
    $display("cycles=%0d checks=%0d errors=%0d", cycle_count, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
